// ==== rv_params.svh ====
// Core widths and opcodes
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_XLEN      32
`define RV_REGS      32
`define RV_REG_AW    5

// Queue depth doubles as the initial input credit count
`define RV_IN_DEPTH  4
`define RV_CREDIT_W  16  // Output credit counter

// Major opcodes
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OPIMM  7'b0010011
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111

`define RV_F7_ALT     7'b0100000  // SUB and SRA

`endif

// ==== rv_pkg.sv ====
// Decode and execute types
`default_nettype none
`include "rv_params.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   rv_word_t;
    typedef logic [`RV_REG_AW-1:0] rv_reg_t;

    typedef enum logic [6:0] {
        // Register-register
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA, SLT, SLTU,
        // Register-immediate
        ADDI, SLTI, SLTIU, XORI, ORI,
        ANDI, SLLI, SRLI, SRAI,
        LUI,
        // Conditional branches
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL,
        JALR,
        ILLEGAL
    } rv_op_e;

    // Decode to execute
    typedef struct packed {
        rv_op_e   op;
        rv_reg_t  rd;
        rv_reg_t  rs1;
        rv_reg_t  rs2;
        rv_word_t imm;    // Already sign extended for the format
        rv_word_t pc;
        logic     wb_en;
    } dec_op_t;

    // Execute to result
    typedef struct packed {
        rv_reg_t  rd;
        rv_word_t value;
        logic     wb_en;
        logic     br_taken;  // Also set for JAL and JALR
        rv_word_t target;
        rv_word_t pc;
        logic     illegal;
    } exec_res_t;

    function automatic logic is_branch(rv_op_e op);
        case (op)
            BEQ, BNE, BLT, BGE, BLTU, BGEU: return 1'b1;
            default:                        return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== rv_stage_if.sv ====
// Stage hand-off and register read interfaces
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

// Valid/ready hand-off, payload held stable until taken
interface rv_stage_if #(
    parameter type payload_t = logic
);
    logic     valid;
    logic     ready;
    payload_t payload;

    modport source (output valid, output payload, input ready);
    modport sink   (input valid, input payload, output ready);
endinterface

// Two-port register read, answered in the same cycle
interface rv_reg_read_if;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    modport requester (
        output rs1_addr, output rs2_addr,
        input  rs1_data, input  rs2_data
    );
    modport responder (
        input  rs1_addr, input  rs2_addr,
        output rs1_data, output rs2_data
    );
endinterface

`default_nettype wire

// ==== rv_decode.sv ====
// Instruction queue and decode
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    input  logic [`RV_XLEN-1:0] instr_pc,
    output logic                in_credit,
    rv_stage_if.source          dec_out
);
    localparam int PTR_W = $clog2(`RV_IN_DEPTH);  // Depth is a power of two
    localparam int CNT_W = PTR_W + 1;

    logic [31:0]      q_instr [`RV_IN_DEPTH];
    rv_word_t         q_pc [`RV_IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    logic [31:0]      head;
    dec_op_t          dec_d;
    dec_op_t          out_q;
    logic             out_valid;

    // Source only sends with a credit in hand, so no full check
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            q_instr[wr_ptr] <= instr;
            q_pc[wr_ptr]    <= instr_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (instr_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(instr_valid) - CNT_W'(pop);
        end
    end

    assign pop       = (count != '0) && (!out_valid || dec_out.ready);
    assign in_credit = pop;  // One credit back per entry leaving
    assign head      = q_instr[rd_ptr];

    always_comb begin
        dec_d       = '0;
        dec_d.rd    = head[11:7];
        dec_d.rs1   = head[19:15];
        dec_d.rs2   = head[24:20];
        dec_d.pc    = q_pc[rd_ptr];
        dec_d.op    = ILLEGAL;
        dec_d.wb_en = 1'b1;
        case (head[6:0])
            `RV_OPC_OP: begin
                case (head[14:12])
                    3'd0: dec_d.op = (head[31:25] == `RV_F7_ALT) ? SUB : ADD;
                    3'd1: dec_d.op = SLL;
                    3'd2: dec_d.op = SLT;
                    3'd3: dec_d.op = SLTU;
                    3'd4: dec_d.op = XOR;
                    3'd5: dec_d.op = (head[31:25] == `RV_F7_ALT) ? SRA : SRL;
                    3'd6: dec_d.op = OR;
                    default: dec_d.op = AND;
                endcase
            end
            `RV_OPC_OPIMM: begin
                dec_d.imm = {{20{head[31]}}, head[31:20]};
                case (head[14:12])
                    3'd0: dec_d.op = ADDI;
                    3'd1: dec_d.op = SLLI;
                    3'd2: dec_d.op = SLTI;
                    3'd3: dec_d.op = SLTIU;
                    3'd4: dec_d.op = XORI;
                    3'd5: dec_d.op = (head[31:25] == `RV_F7_ALT) ? SRAI : SRLI;
                    3'd6: dec_d.op = ORI;
                    default: dec_d.op = ANDI;
                endcase
            end
            `RV_OPC_LUI: begin
                dec_d.op  = LUI;
                dec_d.imm = {head[31:12], 12'b0};
            end
            `RV_OPC_BRANCH: begin
                dec_d.imm = {{20{head[31]}}, head[7], head[30:25], head[11:8], 1'b0};
                case (head[14:12])
                    3'd0: dec_d.op = BEQ;
                    3'd1: dec_d.op = BNE;
                    3'd4: dec_d.op = BLT;
                    3'd5: dec_d.op = BGE;
                    3'd6: dec_d.op = BLTU;
                    3'd7: dec_d.op = BGEU;
                    default: dec_d.op = ILLEGAL;  // 010 and 011 unused
                endcase
            end
            `RV_OPC_JAL: begin
                dec_d.op  = JAL;
                dec_d.imm = {{12{head[31]}}, head[19:12], head[20], head[30:21], 1'b0};
            end
            `RV_OPC_JALR: begin
                dec_d.op  = JALR;
                dec_d.imm = {{20{head[31]}}, head[31:20]};
            end
            default: dec_d.op = ILLEGAL;
        endcase
        if (is_branch(dec_d.op) || dec_d.op == ILLEGAL)
            dec_d.wb_en = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else if (pop)
            out_valid <= 1'b1;
        else if (dec_out.ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (pop)
            out_q <= dec_d;
    end

    assign dec_out.valid   = out_valid;
    assign dec_out.payload = out_q;

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
// ALU, branch resolution and execute register
`timescale 1ns/1ps
`default_nettype none

module rv_execute
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    rv_stage_if.sink         dec_in,
    rv_reg_read_if.requester rd_port,
    rv_stage_if.source       x_out
);
    dec_op_t   d;
    rv_word_t  a;
    rv_word_t  b;
    rv_word_t  value;
    rv_word_t  target;
    logic      taken;
    exec_res_t res_d;
    exec_res_t res_q;
    logic      x_valid;

    assign d                = dec_in.payload;
    assign rd_port.rs1_addr = d.rs1;
    assign rd_port.rs2_addr = d.rs2;
    assign a                = rd_port.rs1_data;  // Forwarded by result stage
    assign b                = rd_port.rs2_data;

    always_comb begin
        value = '0;
        case (d.op)
            ADD:   value = a + b;
            SUB:   value = a - b;
            AND:   value = a & b;
            OR:    value = a | b;
            XOR:   value = a ^ b;
            SLL:   value = a << b[4:0];
            SRL:   value = a >> b[4:0];
            SRA:   value = $signed(a) >>> b[4:0];
            SLT:   value = rv_word_t'($signed(a) < $signed(b));
            SLTU:  value = rv_word_t'(a < b);
            ADDI:  value = a + d.imm;
            SLTI:  value = rv_word_t'($signed(a) < $signed(d.imm));
            SLTIU: value = rv_word_t'(a < d.imm);
            XORI:  value = a ^ d.imm;
            ORI:   value = a | d.imm;
            ANDI:  value = a & d.imm;
            SLLI:  value = a << d.imm[4:0];
            SRLI:  value = a >> d.imm[4:0];
            SRAI:  value = $signed(a) >>> d.imm[4:0];
            LUI:   value = d.imm;
            JAL,
            JALR:  value = d.pc + 32'd4;  // Link address
            default: value = '0;
        endcase
    end

    always_comb begin
        taken  = 1'b0;
        target = '0;
        case (d.op)
            BEQ:  taken = (a == b);
            BNE:  taken = (a != b);
            BLT:  taken = ($signed(a) < $signed(b));
            BGE:  taken = ($signed(a) >= $signed(b));
            BLTU: taken = (a < b);
            BGEU: taken = (a >= b);
            JAL,
            JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
        if (d.op == JALR)
            target = (a + d.imm) & ~rv_word_t'(1);
        else if (is_branch(d.op) || d.op == JAL)
            target = d.pc + d.imm;
    end

    always_comb begin
        res_d          = '0;
        res_d.rd       = d.rd;
        res_d.value    = value;
        res_d.br_taken = taken;
        res_d.target   = target;
        res_d.pc       = d.pc;
        res_d.illegal  = (d.op == ILLEGAL);
        res_d.wb_en    = d.wb_en && (d.op != ILLEGAL);
    end

    // Takes a new op only when empty
    // An older result still held here would be invisible to the read port
    assign dec_in.ready = !x_valid;

    always_ff @(posedge clk) begin
        if (reset)
            x_valid <= 1'b0;
        else if (dec_in.valid && dec_in.ready)
            x_valid <= 1'b1;
        else if (x_out.ready)
            x_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (dec_in.valid && dec_in.ready)
            res_q <= res_d;
    end

    assign x_out.valid   = x_valid;
    assign x_out.payload = res_q;

endmodule

`default_nettype wire

// ==== rv_result.sv ====
// Register file, forwarding and credited result port
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_result
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    rv_stage_if.sink              x_in,
    rv_reg_read_if.responder      rd_port,
    input  logic                  out_credit,
    output logic                  res_valid,
    output logic [`RV_REG_AW-1:0] res_rd,
    output logic [`RV_XLEN-1:0]   res_value,
    output logic                  res_wb,
    output logic                  res_br_taken,
    output logic [`RV_XLEN-1:0]   res_target,
    output logic [`RV_XLEN-1:0]   res_pc,
    output logic                  res_illegal
);
    rv_word_t                regs [`RV_REGS];
    exec_res_t               pend;
    logic                    pend_valid;
    logic [`RV_CREDIT_W-1:0] credits;

    assign res_valid = pend_valid && (credits != '0);
    assign x_in.ready = !pend_valid || res_valid;  // Slot frees as it drains

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
            credits    <= '0;
        end else begin
            if (x_in.valid && x_in.ready)
                pend_valid <= 1'b1;
            else if (res_valid)
                pend_valid <= 1'b0;
            credits <= credits + `RV_CREDIT_W'(out_credit) - `RV_CREDIT_W'(res_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (x_in.valid && x_in.ready)
            pend <= x_in.payload;
    end

    // Writeback on the edge the result leaves, x0 stays zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REGS; i++)
                regs[i] <= '0;
        end else if (res_valid && pend.wb_en && pend.rd != '0) begin
            regs[pend.rd] <= pend.value;
        end
    end

    always_comb begin
        rd_port.rs1_data = regs[rd_port.rs1_addr];
        rd_port.rs2_data = regs[rd_port.rs2_addr];
        if (pend_valid && pend.wb_en && pend.rd == rd_port.rs1_addr)
            rd_port.rs1_data = pend.value;  // Not yet written back
        if (pend_valid && pend.wb_en && pend.rd == rd_port.rs2_addr)
            rd_port.rs2_data = pend.value;
        if (rd_port.rs1_addr == '0)
            rd_port.rs1_data = '0;
        if (rd_port.rs2_addr == '0)
            rd_port.rs2_data = '0;
    end

    assign res_rd       = pend.rd;
    assign res_value    = pend.value;
    assign res_wb       = pend.wb_en;
    assign res_br_taken = pend.br_taken;
    assign res_target   = pend.target;
    assign res_pc       = pend.pc;
    assign res_illegal  = pend.illegal;

endmodule

`default_nettype wire

// ==== rv_core.sv ====
// Decode and execute core top level
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

// Idle pipeline with a credit: res_valid rises on the third edge after instr_valid
module rv_core
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    input  logic [`RV_XLEN-1:0]   instr_pc,
    output logic                  in_credit,
    input  logic                  out_credit,
    output logic                  res_valid,
    output logic [`RV_REG_AW-1:0] res_rd,
    output logic [`RV_XLEN-1:0]   res_value,
    output logic                  res_wb,
    output logic                  res_br_taken,
    output logic [`RV_XLEN-1:0]   res_target,
    output logic [`RV_XLEN-1:0]   res_pc,
    output logic                  res_illegal
);
    rv_stage_if #(.payload_t(dec_op_t))   dec_x ();
    rv_stage_if #(.payload_t(exec_res_t)) x_res ();
    rv_reg_read_if                        reg_rd ();

    rv_decode rv_decode_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .in_credit   (in_credit),
        .dec_out     (dec_x.source)
    );

    rv_execute rv_execute_inst (
        .clk     (clk),
        .reset   (reset),
        .dec_in  (dec_x.sink),
        .rd_port (reg_rd.requester),
        .x_out   (x_res.source)
    );

    rv_result rv_result_inst (
        .clk          (clk),
        .reset        (reset),
        .x_in         (x_res.sink),
        .rd_port      (reg_rd.responder),
        .out_credit   (out_credit),
        .res_valid    (res_valid),
        .res_rd       (res_rd),
        .res_value    (res_value),
        .res_wb       (res_wb),
        .res_br_taken (res_br_taken),
        .res_target   (res_target),
        .res_pc       (res_pc),
        .res_illegal  (res_illegal)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end
endmodule

`default_nettype wire

// ==== tb_rv_core_sva.sv ====
// Core protocol assertions
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module tb_rv_core_sva (
    input logic clk,
    input logic reset,
    input logic instr_valid,
    input logic in_credit,
    input logic out_credit,
    input logic res_valid
);
    int inflight;     // Sent but credit not yet returned
    int outstanding;  // Sent but result not yet presented
    int ocred;        // Output credits held by the DUT

    always_ff @(posedge clk) begin
        if (reset) begin
            inflight    <= 0;
            outstanding <= 0;
            ocred       <= 0;
        end else begin
            inflight    <= inflight + int'(instr_valid) - int'(in_credit);
            outstanding <= outstanding + int'(instr_valid) - int'(res_valid);
            ocred       <= ocred + int'(out_credit) - int'(res_valid);
        end
    end

    no_result_without_credit: assert property (
        @(posedge clk) disable iff (reset) res_valid |-> ocred > 0
    ) else $error("result presented with no output credit");

    inflight_bound: assert property (
        @(posedge clk) disable iff (reset) inflight >= 0 && inflight <= `RV_IN_DEPTH
    ) else $error("input credits returned do not match instructions queued");

    quiet_after_reset: assert property (
        @(posedge clk) reset |=> !in_credit && !res_valid
    ) else $error("credit or result pulse right after reset");

    // Rises on the third edge, so it is first sampled high on the fourth
    idle_latency: assert property (
        @(posedge clk) disable iff (reset)
        instr_valid && outstanding == 0 && ocred > 0 |-> ##4 $rose(res_valid)
    ) else $error("idle pipeline latency is not three cycles");
endmodule

bind rv_core tb_rv_core_sva rv_core_sva_inst (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .in_credit   (in_credit),
    .out_credit  (out_credit),
    .res_valid   (res_valid)
);

`default_nettype wire

// ==== tb_rv_core.sv ====
// Core testbench with reference model
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module tb_rv_core;
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        wb;
        logic        taken;
        logic [31:0] target;
        logic        illegal;
        logic        chk_val;
        logic        chk_tgt;
    } expect_t;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        in_credit;
    logic        out_credit;
    logic        res_valid;
    logic [4:0]  res_rd;
    logic [31:0] res_value;
    logic        res_wb;
    logic        res_br_taken;
    logic [31:0] res_target;
    logic [31:0] res_pc;
    logic        res_illegal;

    logic [31:0] send_q[$];
    logic [31:0] pc_q[$];
    expect_t     exp_q[$];
    logic [31:0] sh[32];        // Shadow register file
    logic [31:0] rng_stim = 32'd67431;
    logic [31:0] rng_gap  = 32'd67431;
    logic [31:0] pc_next  = 32'h0000_1000;
    string       test_name;
    int          src_credits;
    int          ocred;
    logic        last_res_valid;
    int          gap_mode;
    int          checks;
    int          errors;
    int          cycles;

    tb_clock tb_clock_inst (.clk(clk), .reset(reset));

    rv_core rv_core_inst (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                else
                    return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic push_instr(input logic [31:0] word, input expect_t e);
        send_q.push_back(word);
        pc_q.push_back(pc_next);
        exp_q.push_back(e);
        pc_next = pc_next + 32'd4;
    endtask

    // kind 0 register, 1 immediate, 2 LUI
    task automatic issue_alu(input int kind, input logic [2:0] f3, input logic alt,
                             input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [31:0] rnd);
        logic [31:0] word;
        logic [11:0] imm12;
        expect_t     e;
        e = '0;
        e.pc = pc_next;
        e.rd = rd;
        e.wb = 1'b1;
        e.chk_val = 1'b1;
        if (kind == 0) begin
            word = {(alt ? 7'h20 : 7'h00), rs2, rs1, f3, rd, `RV_OPC_OP};
            e.value = alu_ref(f3, alt, sh[rs1], sh[rs2]);
        end else if (kind == 1) begin
            if (f3 == 3'd1 || f3 == 3'd5)
                imm12 = {(alt ? 7'h20 : 7'h00), rnd[4:0]};
            else
                imm12 = rnd[11:0];
            word = {imm12, rs1, f3, rd, `RV_OPC_OPIMM};
            e.value = alu_ref(f3, alt, sh[rs1], {{20{imm12[11]}}, imm12});
        end else begin
            word = {rnd[31:12], rd, `RV_OPC_LUI};
            e.value = {rnd[31:12], 12'b0};
        end
        push_instr(word, e);
        if (rd != 5'd0)
            sh[rd] = e.value;
    endtask

    task automatic issue_random_alu();
        int   kind;
        logic [2:0] f3;
        logic alt;
        rng_stim = xorshift(rng_stim);
        kind = int'(rng_stim[1:0]) % 3;
        f3   = rng_stim[4:2];
        alt  = rng_stim[5] && (f3 == 3'd5 || (f3 == 3'd0 && kind == 0));
        issue_alu(kind, f3, alt, rng_stim[10:6], rng_stim[15:11], rng_stim[20:16],
                  xorshift(rng_stim));
    endtask

    task automatic issue_branch();
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [12:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        expect_t     e;
        rng_stim = xorshift(rng_stim);
        case (rng_stim[2:0] % 6)
            0: f3 = 3'd0;
            1: f3 = 3'd1;
            2: f3 = 3'd4;
            3: f3 = 3'd5;
            4: f3 = 3'd6;
            default: f3 = 3'd7;
        endcase
        rs1 = rng_stim[7:3];
        rs2 = rng_stim[8] ? rs1 : rng_stim[13:9];  // Equal operands now and then
        imm = {rng_stim[25:14], 1'b0};
        a = sh[rs1];
        b = sh[rs2];
        e = '0;
        e.pc = pc_next;
        e.chk_tgt = 1'b1;
        e.target = pc_next + {{19{imm[12]}}, imm};
        case (f3)
            3'd0: e.taken = (a == b);
            3'd1: e.taken = (a != b);
            3'd4: e.taken = ($signed(a) < $signed(b));
            3'd5: e.taken = ($signed(a) >= $signed(b));
            3'd6: e.taken = (a < b);
            default: e.taken = (a >= b);
        endcase
        push_instr({imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH}, e);
    endtask

    task automatic issue_jump_or_illegal();
        logic [20:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [6:0]  opc;
        expect_t     e;
        rng_stim = xorshift(rng_stim);
        rd  = rng_stim[6:2];
        rs1 = rng_stim[11:7];
        imm = {rng_stim[31:12], 1'b0};
        e = '0;
        e.pc = pc_next;
        if (rng_stim[1:0] == 2'd3) begin
            case (rng_stim[13:12])
                0: opc = 7'b0000011;  // Load
                1: opc = 7'b0100011;  // Store
                2: opc = 7'b0010111;  // AUIPC
                default: opc = 7'b1110011;
            endcase
            e.illegal = 1'b1;
            push_instr({rng_stim[31:7], opc}, e);
        end else begin
            e.rd = rd;
            e.wb = 1'b1;
            e.taken = 1'b1;
            e.chk_val = 1'b1;
            e.chk_tgt = 1'b1;
            e.value = pc_next + 32'd4;
            if (rng_stim[0]) begin
                e.target = pc_next + {{11{imm[20]}}, imm};
                push_instr({imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL}, e);
            end else begin
                e.target = (sh[rs1] + {{20{imm[20]}}, imm[20:9]}) & ~32'd1;
                push_instr({imm[20:9], rs1, 3'b000, rd, `RV_OPC_JALR}, e);
            end
            if (rd != 5'd0)
                sh[rd] = e.value;
        end
    endtask

    task automatic compare_field(input string field, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        checks++;
        assert (exp_v == act_v) else begin
            $display("error %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic wait_drain();
        while (send_q.size() != 0 || exp_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic finish_test(input int err_start);
        wait_drain();
        $display("%s done, %0d errors", test_name, errors - err_start);
    endtask

    // Source side, one credit per send
    always @(negedge clk) begin
        if (reset) begin
            src_credits = `RV_IN_DEPTH;
            instr_valid <= 1'b0;
        end else begin
            if (in_credit)
                src_credits++;
            if (send_q.size() != 0 && src_credits > 0) begin
                instr_valid <= 1'b1;
                instr       <= send_q.pop_front();
                instr_pc    <= pc_q.pop_front();
                src_credits--;
            end else begin
                instr_valid <= 1'b0;
            end
        end
    end

    // Output credits, kept low so gaps actually stall the pipeline
    always @(negedge clk) begin
        if (reset) begin
            ocred          = 0;
            last_res_valid = 1'b0;
            out_credit    <= 1'b0;
        end else begin
            ocred = ocred + int'(out_credit) - int'(last_res_valid);
            rng_gap = xorshift(rng_gap);
            if (gap_mode == 0)
                out_credit <= (ocred < 2);
            else
                out_credit <= (rng_gap[1:0] == 2'd0) && (ocred < 3);
            last_res_valid = res_valid;
        end
    end

    always @(negedge clk) begin : monitor
        expect_t e;
        if (!reset && res_valid) begin
            if (exp_q.size() == 0) begin
                $display("result arrived with no instruction outstanding in %s", test_name);
                errors++;
            end else begin
                e = exp_q.pop_front();
                compare_field("pc", e.pc, res_pc);
                compare_field("wb", 32'(e.wb), 32'(res_wb));
                compare_field("illegal", 32'(e.illegal), 32'(res_illegal));
                compare_field("taken", 32'(e.taken), 32'(res_br_taken));
                if (e.chk_val) begin
                    compare_field("rd", 32'(e.rd), 32'(res_rd));
                    compare_field("value", e.value, res_value);
                end
                if (e.chk_tgt)
                    compare_field("target", e.target, res_target);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            $display("timeout after %0d cycles with %0d results missing", cycles, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int   err_start;
        logic [4:0] prev;
        logic [4:0] rd;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        out_credit  = 1'b0;
        gap_mode    = 0;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        for (int i = 0; i < 32; i++)
            sh[i] = '0;
        @(negedge reset);
        repeat (2) @(negedge clk);

        test_name = "alu_ops";
        err_start = errors;
        for (int i = 0; i < 80; i++)
            issue_random_alu();
        finish_test(err_start);

        test_name = "forwarding";
        err_start = errors;
        prev = 5'd1;
        for (int i = 0; i < 60; i++) begin
            rng_stim = xorshift(rng_stim);
            rd = (rng_stim[4:0] == 5'd0) ? 5'd7 : rng_stim[4:0];
            issue_alu(int'(rng_stim[5]), rng_stim[5] ? 3'd0 : rng_stim[8:6], 1'b0, rd,
                      prev, rng_stim[13:9], xorshift(rng_stim));
            prev = rd;
        end
        finish_test(err_start);

        test_name = "branches";
        err_start = errors;
        for (int i = 0; i < 60; i++)
            issue_branch();
        finish_test(err_start);

        test_name = "jumps_illegal";
        err_start = errors;
        for (int i = 0; i < 50; i++)
            issue_jump_or_illegal();
        finish_test(err_start);

        test_name = "credits";
        err_start = errors;
        gap_mode = 1;
        for (int i = 0; i < 50; i++)
            issue_random_alu();
        finish_test(err_start);

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end
endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
rv_pkg.sv
rv_stage_if.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
tb_clock.sv
tb_rv_core_sva.sv
tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f tb.f -o sim_rv_core

./obj_dir/sim_rv_core | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
